/* project.f */
logic/ntm_math_pkg.sv
logic/ntm_ctrl_pkg.sv
logic/ntm_scalar_multiplier.sv
logic/ntm_scalar_product.sv
tb/ntm_scalar_product_tb.sv

/* Bender.yml */
package:
  name: ntm_scalar_product

sources:
  # Packages first, then RTL bottom-up
  - logic/ntm_math_pkg.sv
  - logic/ntm_ctrl_pkg.sv
  - logic/ntm_scalar_multiplier.sv
  - logic/ntm_scalar_product.sv
  - target: simulation
    files:
      - tb/ntm_scalar_product_tb.sv

/* tb/ntm_scalar_product_tb.sv */
`timescale 1ns/10ps

module ntm_scalar_product_tb;

  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  // Second strobe to DATA_OUT_ENABLE, in cycles
  localparam int RESULT_LAT   = MUL_CYCLES + 2;
  localparam int ELEM_TIMEOUT = 200;

  // Operand arrival orders
  localparam int ORD_SAME    = 0;
  localparam int ORD_A_FIRST = 1;
  localparam int ORD_B_FIRST = 2;
  localparam int ORD_A_TWICE = 3;

  logic      CLK;
  logic      RST;
  logic      START;
  logic      READY;
  logic      DATA_A_IN_ENABLE;
  logic      DATA_B_IN_ENABLE;
  logic      DATA_OUT_ENABLE;
  ntm_len_t  LENGTH_IN;
  ntm_data_t DATA_A_IN;
  ntm_data_t DATA_B_IN;
  ntm_data_t DATA_OUT;

  integer seed;
  int     err_cnt;
  int     test_cnt;
  int     fail_cnt;
  int     test_err_base;
  // Free-running cycle index, and its value at the last second strobe
  int     cycle_cnt;
  int     strobe_cycle;
  int     doe_cnt;

  // Element pairs of the vector under test
  ntm_data_t vec_a[$];
  ntm_data_t vec_b[$];
  int        vec_order[$];

  ntm_scalar_product UUT (.*);

  ////////////////////
  // Clock, monitors
  ////////////////////

  initial begin
    CLK = 1'b0;
    forever #20 CLK = ~CLK;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
  end

  // Pulses counted mid-cycle, outputs settled
  always @(negedge CLK) begin
    if (DATA_OUT_ENABLE === 1'b1) begin
      doe_cnt <= doe_cnt + 1;
    end
  end

  ////////////////////
  // Protocol checks
  ////////////////////

  doe_pulse_a: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else note_failure("DATA_OUT_ENABLE stayed high for more than one cycle");

  ready_pulse_a: assert property (@(posedge CLK) disable iff (RST)
    READY |=> !READY)
    else note_failure("READY stayed high for more than one cycle");

  // READY alone only for an empty vector
  ready_with_sum_a: assert property (@(posedge CLK) disable iff (RST)
    READY |-> (DATA_OUT_ENABLE || DATA_OUT == '0))
    else note_failure("READY came without a final sum");

  // Sum moves with its strobe, or drops to zero on START
  sum_stable_a: assert property (@(posedge CLK) disable iff (RST)
    (!DATA_OUT_ENABLE && DATA_OUT != '0) |-> $stable(DATA_OUT))
    else note_failure("DATA_OUT changed without DATA_OUT_ENABLE");

  ////////////////////
  // Helpers
  ////////////////////

  task automatic note_failure(input string msg);
    $display("%s at %0t", msg, $time);
    err_cnt++;
  endtask

  task automatic check_hex(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("ERROR: %s expected 0x%08h actual 0x%08h", name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic check_quiet();
    check_hex("READY", READY, 1'b0);
    check_hex("DATA_OUT_ENABLE", DATA_OUT_ENABLE, 1'b0);
    check_hex("DATA_OUT", DATA_OUT, '0);
  endtask

  // All inputs change 2 ns after the rising edge
  task automatic drive(input logic st, input logic ea, input ntm_data_t da,
                       input logic eb, input ntm_data_t db);
    @(posedge CLK);
    #2;
    START            = st;
    DATA_A_IN_ENABLE = ea;
    DATA_A_IN        = da;
    DATA_B_IN_ENABLE = eb;
    DATA_B_IN        = db;
  endtask

  // Junk on the data lines, no strobe
  task automatic idle_cycles(input int n);
    repeat (n) begin
      drive(1'b0, 1'b0, $random(seed), 1'b0, $random(seed));
    end
  endtask

  task automatic pulse_start(input ntm_len_t len);
    drive(1'b1, 1'b0, '0, 1'b0, '0);
    LENGTH_IN = len;
  endtask

  task automatic send_pair(input ntm_data_t a, input ntm_data_t b, input int order);
    int gap;
    gap = $unsigned($random(seed)) % 3;
    case (order)
      ORD_SAME: begin
        drive(1'b0, 1'b1, a, 1'b1, b);
      end
      ORD_B_FIRST: begin
        drive(1'b0, 1'b0, a, 1'b1, b);
        idle_cycles(gap);
        drive(1'b0, 1'b1, a, 1'b0, b);
      end
      ORD_A_TWICE: begin
        // Repeat strobe carries another value, dropped by the DUT
        drive(1'b0, 1'b1, a, 1'b0, b);
        idle_cycles(gap);
        drive(1'b0, 1'b1, ~a, 1'b0, b);
        drive(1'b0, 1'b0, a, 1'b1, b);
      end
      default: begin
        drive(1'b0, 1'b1, a, 1'b0, b);
        idle_cycles(gap);
        drive(1'b0, 1'b0, a, 1'b1, b);
      end
    endcase
    strobe_cycle = cycle_cnt;
    idle_cycles(1);
  endtask

  task automatic stop_on_timeout(input string what);
    $display("Timeout: %s not seen within %0d cycles", what, ELEM_TIMEOUT);
    $display("Simulation finished: FAIL");
    $finish;
  endtask

  // DATA_OUT_ENABLE, or READY for an empty vector
  task automatic wait_output(input bit want_ready);
    int waited;
    waited = 0;
    @(negedge CLK);
    while ((want_ready ? READY : DATA_OUT_ENABLE) !== 1'b1 && waited < ELEM_TIMEOUT) begin
      @(negedge CLK);
      waited++;
    end
    if ((want_ready ? READY : DATA_OUT_ENABLE) !== 1'b1) begin
      stop_on_timeout(want_ready ? "READY" : "DATA_OUT_ENABLE");
    end
  endtask

  task automatic add_elem(input ntm_data_t a, input ntm_data_t b, input int order);
    vec_a.push_back(a);
    vec_b.push_back(b);
    vec_order.push_back(order);
  endtask

  // Reference model: running sum of products, mod 2^32
  task automatic run_vector(input bit busy_start);
    ntm_data_t exp_sum;
    int        len;
    int        base;
    int        i;
    len     = vec_a.size();
    exp_sum = '0;
    base    = doe_cnt;
    pulse_start(ntm_len_t'(len));
    if (len == 0) begin
      idle_cycles(1);
      wait_output(1'b1);
      check_hex("DATA_OUT", DATA_OUT, '0);
      check_hex("DATA_OUT_ENABLE", DATA_OUT_ENABLE, 1'b0);
    end
    for (i = 0; i < len; i++) begin
      idle_cycles($unsigned($random(seed)) % 4);
      send_pair(vec_a[i], vec_b[i], vec_order[i]);
      if (busy_start && i == 0) begin
        // Lands in MULTIPLY, DUT must ignore it
        pulse_start(ntm_len_t'(5));
        idle_cycles(1);
      end
      exp_sum = exp_sum + vec_a[i] * vec_b[i];
      wait_output(1'b0);
      check_hex("DATA_OUT", DATA_OUT, exp_sum);
      check_hex("READY", READY, i == len - 1);
      check_hex("result latency", cycle_cnt - strobe_cycle, RESULT_LAT);
    end
    idle_cycles(1);
    check_hex("DATA_OUT_ENABLE count", doe_cnt - base, len);
    vec_a.delete();
    vec_b.delete();
    vec_order.delete();
  endtask

  task automatic end_test(input string name);
    test_cnt++;
    if (err_cnt == test_err_base) begin
      $display("Test %0d, %s: passed", test_cnt, name);
    end else begin
      fail_cnt++;
      $display("Test %0d, %s: failed, %0d errors", test_cnt, name, err_cnt - test_err_base);
    end
  endtask

  ////////////////////
  // Tests
  ////////////////////

  initial begin
    int len;
    seed             = 33;
    RST              = 1'b1;
    START            = 1'b0;
    LENGTH_IN        = '0;
    DATA_A_IN_ENABLE = 1'b0;
    DATA_B_IN_ENABLE = 1'b0;
    DATA_A_IN        = '0;
    DATA_B_IN        = '0;

    // Quiet outputs in reset and until the first START
    test_err_base = err_cnt;
    repeat (8) begin
      @(posedge CLK);
      #2;
      check_quiet();
    end
    RST = 1'b0;
    repeat (4) begin
      @(negedge CLK);
      check_quiet();
    end
    end_test("reset and idle outputs");

    test_err_base = err_cnt;
    add_elem($random(seed), $random(seed), ORD_A_FIRST);
    run_vector(1'b0);
    end_test("length one");

    test_err_base = err_cnt;
    repeat (6) begin
      len = $unsigned($random(seed)) % 8 + 1;
      repeat (len) begin
        add_elem($random(seed), $random(seed), $unsigned($random(seed)) % 3);
      end
      run_vector(1'b0);
    end
    end_test("random vectors");

    test_err_base = err_cnt;
    add_elem($random(seed), $random(seed), ORD_A_FIRST);
    add_elem($random(seed), $random(seed), ORD_B_FIRST);
    add_elem($random(seed), $random(seed), ORD_SAME);
    add_elem($random(seed), $random(seed), ORD_A_TWICE);
    run_vector(1'b0);
    end_test("operand order");

    // All-ones products and sums past 2^32
    test_err_base = err_cnt;
    add_elem('1, '1, ORD_SAME);
    add_elem('1, 32'h3, ORD_A_FIRST);
    add_elem('1, '1, ORD_B_FIRST);
    add_elem('1, 32'h2, ORD_SAME);
    run_vector(1'b0);
    end_test("wrap-around");

    test_err_base = err_cnt;
    run_vector(1'b0);
    repeat (3) begin
      add_elem($random(seed), $random(seed), ORD_SAME);
    end
    run_vector(1'b1);
    end_test("empty vector and busy START");

    $display("Tests: %0d, failed: %0d, errors: %0d", test_cnt, fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

/* logic/ntm_scalar_product.sv */
`timescale 1ns/10ps

// Streaming dot product
// DATA_OUT = sum of DATA_A_IN * DATA_B_IN over LENGTH_IN elements
module ntm_scalar_product (
  input  logic                    CLK,
  input  logic                    RST,

  // Control
  input  logic                    START,
  output logic                    READY,

  input  logic                    DATA_A_IN_ENABLE,
  input  logic                    DATA_B_IN_ENABLE,
  output logic                    DATA_OUT_ENABLE,

  // Data
  input  ntm_ctrl_pkg::ntm_len_t  LENGTH_IN,
  input  ntm_math_pkg::ntm_data_t DATA_A_IN,
  input  ntm_math_pkg::ntm_data_t DATA_B_IN,
  output ntm_math_pkg::ntm_data_t DATA_OUT
);

  import ntm_math_pkg::*;
  import ntm_ctrl_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // Sequencer
  ntm_sp_state_t state;

  // Vector length, latched at START
  ntm_len_t len_q;
  // Elements already accumulated
  ntm_len_t idx;
  ntm_len_t idx_next;

  // Operand pair and fill flags
  ntm_operands_t mul_operands;
  logic          a_full;
  logic          b_full;
  logic          a_take;
  logic          b_take;

  // Multiplier handshake
  logic      mul_start;
  logic      mul_ready;
  ntm_data_t mul_data;

  ////////////////////
  // Operand capture
  ////////////////////

  // Strobe counts only for an empty half while collecting
  // a repeat strobe on a held half is simply dropped
  assign a_take = (state == COLLECT) && DATA_A_IN_ENABLE && !a_full;
  assign b_take = (state == COLLECT) && DATA_B_IN_ENABLE && !b_full;

  always_ff @(posedge CLK) begin
    if (a_take) begin
      mul_operands.a <= DATA_A_IN;
    end
    if (b_take) begin
      mul_operands.b <= DATA_B_IN;
    end
  end

  // Kick the multiplier the cycle after the pair completes
  assign mul_start = (state == COLLECT) && a_full && b_full;

  assign idx_next = idx + 1'b1;

  ////////////////////
  // Sequencer
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= IDLE;
      len_q           <= '0;
      idx             <= '0;
      a_full          <= 1'b0;
      b_full          <= 1'b0;
      DATA_OUT        <= '0;
      DATA_OUT_ENABLE <= 1'b0;
      READY           <= 1'b0;
    end else begin
      // Pulses by default
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;

      // Fill flags follow the capture above
      if (a_take) begin
        a_full <= 1'b1;
      end
      if (b_take) begin
        b_full <= 1'b1;
      end

      case (state)
        IDLE: begin
          // START ignored anywhere else
          if (START) begin
            len_q    <= LENGTH_IN;
            idx      <= '0;
            DATA_OUT <= '0;
            // Empty vector finishes at once
            if (LENGTH_IN == '0) begin
              READY <= 1'b1;
            end else begin
              state <= COLLECT;
            end
          end
        end

        COLLECT: begin
          // mul_start is high this cycle
          if (mul_start) begin
            state <= MULTIPLY;
          end
        end

        MULTIPLY: begin
          // Sum registered on the edge the product arrives
          if (mul_ready) begin
            DATA_OUT        <= DATA_OUT + mul_data;
            DATA_OUT_ENABLE <= 1'b1;
            idx             <= idx_next;
            // Last element, READY rides with the final sum
            READY           <= (idx_next == len_q);
            state           <= ACCUMULATE;
          end
        end

        ACCUMULATE: begin
          // Release the pair for the next element
          a_full <= 1'b0;
          b_full <= 1'b0;
          if (idx == len_q) begin
            state <= IDLE;
          end else begin
            state <= COLLECT;
          end
        end

        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////
  // Multiplier
  ////////////////////

  ntm_scalar_multiplier multiplier_i (
    .CLK      (CLK),
    .RST      (RST),

    .START    (mul_start),
    .READY    (mul_ready),

    .OPERANDS (mul_operands),
    .DATA_OUT (mul_data)
  );

endmodule

/* logic/ntm_scalar_multiplier.sv */
`timescale 1ns/10ps

// Sequential shift-add multiplier, unsigned
// Keeps the low DATA_W bits of the product
module ntm_scalar_multiplier (
  input  logic                       CLK,
  input  logic                       RST,

  // Control
  input  logic                       START,
  output logic                       READY,

  // Data
  input  ntm_math_pkg::ntm_operands_t OPERANDS,
  output ntm_math_pkg::ntm_data_t     DATA_OUT
);

  import ntm_math_pkg::*;

  ////////////////////
  // Signals
  ////////////////////

  // Shifted copy of operand a
  ntm_data_t mcand;
  // Remaining bits of operand b, LSB first
  ntm_data_t mplier;
  // Partial product
  ntm_data_t acc;

  // Iterations done so far
  logic [MUL_CNT_W-1:0] cnt;
  logic                 busy;

  ////////////////////
  // Datapath
  ////////////////////

  // Bit 0 of b is handled on the START edge itself,
  // so 31 further edges finish the job and READY
  // lands exactly MUL_CYCLES cycles after START
  always_ff @(posedge CLK) begin
    if (START) begin
      acc    <= OPERANDS.b[0] ? OPERANDS.a : '0;
      mcand  <= {OPERANDS.a[DATA_W-2:0], 1'b0};
      mplier <= {1'b0, OPERANDS.b[DATA_W-1:1]};
    end else if (busy) begin
      // Add shifted multiplicand for a set bit
      if (mplier[0]) begin
        acc <= acc + mcand;
      end
      mcand  <= {mcand[DATA_W-2:0], 1'b0};
      mplier <= {1'b0, mplier[DATA_W-1:1]};
    end
  end

  ////////////////////
  // Control
  ////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      busy  <= 1'b0;
      cnt   <= '0;
      READY <= 1'b0;
    end else begin
      // Single-cycle pulse
      READY <= 1'b0;
      if (START) begin
        busy <= 1'b1;
        cnt  <= MUL_CNT_W'(1);
      end else if (busy) begin
        cnt <= cnt + 1'b1;
        // Last bit retired on this edge
        if (cnt == MUL_CNT_W'(MUL_CYCLES - 1)) begin
          busy  <= 1'b0;
          READY <= 1'b1;
        end
      end
    end
  end

  // Product stays put until the next START
  assign DATA_OUT = acc;

endmodule

/* logic/ntm_ctrl_pkg.sv */
// Control side of the dot-product engine
// Vector length and sequencer states
package ntm_ctrl_pkg;

  ////////////////////
  // Lengths
  ////////////////////

  // Vector length, also used as element index
  localparam int LEN_W = 8;

  typedef logic [LEN_W-1:0] ntm_len_t;

  ////////////////////
  // Sequencer
  ////////////////////

  // IDLE        waiting for START
  // COLLECT     filling the operand pair
  // MULTIPLY    multiplier busy
  // ACCUMULATE  sum shown, pair released
  typedef enum logic [1:0] {
    IDLE       = 2'd0,
    COLLECT    = 2'd1,
    MULTIPLY   = 2'd2,
    ACCUMULATE = 2'd3
  } ntm_sp_state_t;

endpackage

/* logic/ntm_math_pkg.sv */
// Arithmetic side of the dot-product engine
// Element width, operand pairing and multiplier timing
package ntm_math_pkg;

  ////////////////////
  // Widths
  ////////////////////

  // One vector element, one product, one running sum
  localparam int DATA_W = 32;

  typedef logic [DATA_W-1:0] ntm_data_t;

  // One element pair as handed to the multiplier
  // a sits in the upper half, b in the lower
  typedef struct packed {
    ntm_data_t a;
    ntm_data_t b;
  } ntm_operands_t;

  ////////////////////
  // Multiplier timing
  ////////////////////

  // Shift-add retires one multiplier bit per cycle
  localparam int MUL_CYCLES = DATA_W;

  // Iteration counter width
  localparam int MUL_CNT_W = $clog2(MUL_CYCLES);

endpackage
